/* common/video_pkg.sv */
//////////////////////////////////////////////////
// video engine shared types
// default modeline loaded at reset, fallback colour
//////////////////////////////////////////////////

package video_pkg;

	//////////////////////////////////////////////////
	// widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [23:0] pixel_t;    // rgb, red in upper byte
	typedef logic [15:0] coord_t;    // active size, raster position
	typedef logic [7:0]  porch_t;    // porch / sync width
	typedef logic [7:0]  cediv_t;    // clk_sys cycles per pixel, 0 acts as 1
	typedef logic [23:0] pixcount_t; // pixel count, vram address

	//////////////////////////////////////////////////
	// reset modeline, 256x240 at 1/16 clk_sys
	//////////////////////////////////////////////////

	localparam coord_t DEFAULT_H   = 16'd256;
	localparam porch_t DEFAULT_HFP = 8'd10;
	localparam porch_t DEFAULT_HS  = 8'd24;
	localparam porch_t DEFAULT_HBP = 8'd41;

	localparam coord_t DEFAULT_V   = 16'd240;
	localparam porch_t DEFAULT_VFP = 8'd2;
	localparam porch_t DEFAULT_VS  = 8'd3;
	localparam porch_t DEFAULT_VBP = 8'd16;

	localparam cediv_t DEFAULT_CE_DIV = 8'd16;

	// shown until a whole frame sits in vram
	localparam pixel_t FALLBACK_COLOR = 24'hd19628; // dark yellow

endpackage

/* hdl/mode_latch.sv */
//////////////////////////////////////////////////
// modeline holding register
// takes a new modeline only in vblank, then pulses apply
//////////////////////////////////////////////////

`timescale 1ns/1ns

module mode_latch (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                vblank,
	// host modeline port
	input  logic                mode_valid,
	output logic                mode_ready,
	input  video_pkg::coord_t   mode_h,
	input  video_pkg::porch_t   mode_hfp,
	input  video_pkg::porch_t   mode_hs,
	input  video_pkg::porch_t   mode_hbp,
	input  video_pkg::coord_t   mode_v,
	input  video_pkg::porch_t   mode_vfp,
	input  video_pkg::porch_t   mode_vs,
	input  video_pkg::porch_t   mode_vbp,
	input  video_pkg::cediv_t   mode_ce_div,
	// active modeline
	output video_pkg::coord_t   cur_h,
	output video_pkg::porch_t   cur_hfp,
	output video_pkg::porch_t   cur_hs,
	output video_pkg::porch_t   cur_hbp,
	output video_pkg::coord_t   cur_v,
	output video_pkg::porch_t   cur_vfp,
	output video_pkg::porch_t   cur_vs,
	output video_pkg::porch_t   cur_vbp,
	output video_pkg::cediv_t   cur_ce_div,
	output logic                mode_apply // restart pulse for the other blocks
);
	import video_pkg::*;

	logic take; // handshake this cycle

	// only open in vblank so a visible line is never cut
	assign mode_ready = vblank;
	assign take       = mode_valid & mode_ready;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cur_h      <= DEFAULT_H;
			cur_hfp    <= DEFAULT_HFP;
			cur_hs     <= DEFAULT_HS;
			cur_hbp    <= DEFAULT_HBP;
			cur_v      <= DEFAULT_V;
			cur_vfp    <= DEFAULT_VFP;
			cur_vs     <= DEFAULT_VS;
			cur_vbp    <= DEFAULT_VBP;
			cur_ce_div <= DEFAULT_CE_DIV;
			mode_apply <= 1'b0;
		end else begin
			mode_apply <= take; // one cycle after capture
			if (take) begin
				cur_h      <= mode_h;
				cur_hfp    <= mode_hfp;
				cur_hs     <= mode_hs;
				cur_hbp    <= mode_hbp;
				cur_v      <= mode_v;
				cur_vfp    <= mode_vfp;
				cur_vs     <= mode_vs;
				cur_vbp    <= mode_vbp;
				cur_ce_div <= mode_ce_div;
			end
		end
	end

endmodule

/* raster/raster_timing.sv */
//////////////////////////////////////////////////
// raster timing from the active modeline
// pixel enable divider, h/v counters, sync and blank
//////////////////////////////////////////////////

`timescale 1ns/1ns

module raster_timing (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              mode_apply,
	input  video_pkg::coord_t cur_h,
	input  video_pkg::porch_t cur_hfp,
	input  video_pkg::porch_t cur_hs,
	input  video_pkg::porch_t cur_hbp,
	input  video_pkg::coord_t cur_v,
	input  video_pkg::porch_t cur_vfp,
	input  video_pkg::porch_t cur_vs,
	input  video_pkg::porch_t cur_vbp,
	input  video_pkg::cediv_t cur_ce_div,
	output logic              ce_pix,
	output video_pkg::coord_t hcount,
	output video_pkg::coord_t vcount,
	output logic              active,
	output logic              hsync,
	output logic              vsync,
	output logic              vblank,
	output logic              vblank_start
);
	import video_pkg::*;

	cediv_t ce_cnt;
	cediv_t ce_last;     // last divider count
	coord_t hs_begin;    // first hsync pixel
	coord_t hs_end;      // first pixel after hsync
	coord_t h_last;      // last pixel of a line
	coord_t vs_begin;
	coord_t vs_end;
	coord_t v_last;      // last line of a frame
	logic   vblank_d;    // vblank one cycle ago

	//////////////////////////////////////////////////
	// window edges from the modeline
	//////////////////////////////////////////////////

	assign hs_begin = cur_h + coord_t'(cur_hfp);
	assign hs_end   = hs_begin + coord_t'(cur_hs);
	assign h_last   = hs_end + coord_t'(cur_hbp) - 16'd1;

	assign vs_begin = cur_v + coord_t'(cur_vfp);
	assign vs_end   = vs_begin + coord_t'(cur_vs);
	assign v_last   = vs_end + coord_t'(cur_vbp) - 16'd1;

	//////////////////////////////////////////////////
	// pixel clock enable
	//////////////////////////////////////////////////

	// divider of 0 behaves as 1, enable every cycle
	assign ce_last = (cur_ce_div == 8'd0) ? 8'd0 : cur_ce_div - 8'd1;
	assign ce_pix  = (ce_cnt == 8'd0);

	always_ff @(posedge clk_sys) begin
		if (reset || mode_apply) begin
			ce_cnt <= 8'd0; // enable on the first cycle after restart
		end else if (ce_cnt >= ce_last) begin
			ce_cnt <= 8'd0;
		end else begin
			ce_cnt <= ce_cnt + 8'd1;
		end
	end

	//////////////////////////////////////////////////
	// h/v counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset || mode_apply) begin
			hcount <= 16'd0;
			vcount <= 16'd0;
		end else if (ce_pix) begin
			if (hcount >= h_last) begin // end of line
				hcount <= 16'd0;
				if (vcount >= v_last)
					vcount <= 16'd0; // end of frame
				else
					vcount <= vcount + 16'd1;
			end else begin
				hcount <= hcount + 16'd1;
			end
		end
	end

	// window decode
	assign active = (hcount < cur_h) && (vcount < cur_v);
	assign hsync  = (hcount >= hs_begin) && (hcount < hs_end);
	assign vsync  = (vcount >= vs_begin) && (vcount < vs_end);
	assign vblank = (vcount >= cur_v);

	// single pulse on entry to blanking
	always_ff @(posedge clk_sys) begin
		if (reset)
			vblank_d <= 1'b0;
		else
			vblank_d <= vblank;
	end

	assign vblank_start = vblank & ~vblank_d;

endmodule

/* vram/blit_writer.sv */
//////////////////////////////////////////////////
// pixel stream write path
// sequential vram addresses, frame fill tracking
//////////////////////////////////////////////////

`timescale 1ns/1ns

module blit_writer #(
	parameter int VRAM_DEPTH = 4096
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 mode_apply,
	input  logic                 vblank_start,
	input  video_pkg::coord_t    cur_h,
	input  video_pkg::coord_t    cur_v,
	input  logic                 px_valid,
	input  video_pkg::pixel_t    px_data,
	output logic                 px_ready,
	output logic                 wr_en,
	output video_pkg::pixcount_t wr_addr,
	output video_pkg::pixel_t    wr_data,
	output logic                 frame_full
);
	import video_pkg::*;

	logic [31:0] frame_prod;  // h * v, full width
	pixcount_t   frame_size;  // pixels per frame, capped at vram size
	pixcount_t   wr_count;    // pixels taken this frame
	pixcount_t   base_count;  // count after any restart this cycle
	logic        accept;

	assign frame_prod = 32'(cur_h) * 32'(cur_v);
	assign frame_size = (frame_prod > 32'(VRAM_DEPTH)) ? pixcount_t'(VRAM_DEPTH)
	                                                   : pixcount_t'(frame_prod);

	assign px_ready = (wr_count != frame_size); // back-pressure once full
	assign accept   = px_valid & px_ready;

	// vblank start and mode change both restart at address 0
	assign base_count = (vblank_start || mode_apply) ? 24'd0 : wr_count;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_count <= 24'd0;
			wr_en    <= 1'b0;
		end else begin
			wr_en    <= accept;
			wr_count <= base_count + pixcount_t'(accept);
		end
	end

	// write payload, no reset
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			wr_addr <= base_count;
			wr_data <= px_data;
		end
	end

	// sticky until the modeline changes
	always_ff @(posedge clk_sys) begin
		if (reset || mode_apply)
			frame_full <= 1'b0;
		else if (wr_count == frame_size)
			frame_full <= 1'b1;
	end

endmodule

/* vram/scanout.sv */
//////////////////////////////////////////////////
// video ram and scanout
// reads at the raster position, registers rgb with sync
//////////////////////////////////////////////////

`timescale 1ns/1ns

module scanout #(
	parameter int VRAM_DEPTH = 4096
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ce_pix,
	input  logic                 active,
	input  logic                 hsync,
	input  logic                 vsync,
	input  video_pkg::coord_t    hcount,
	input  video_pkg::coord_t    vcount,
	input  video_pkg::coord_t    cur_h,
	input  logic                 wr_en,
	input  video_pkg::pixcount_t wr_addr,
	input  video_pkg::pixel_t    wr_data,
	input  logic                 frame_full,
	output logic [7:0]           vga_r,
	output logic [7:0]           vga_g,
	output logic [7:0]           vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 vga_de
);
	import video_pkg::*;

	localparam int ADDR_W = (VRAM_DEPTH > 1) ? $clog2(VRAM_DEPTH) : 1;

	pixel_t    vram [VRAM_DEPTH]; // one word per pixel
	pixcount_t rd_addr;
	pixel_t    rd_q;              // pixel read at the last enable
	logic      full_q;            // frame_full at the last enable
	pixel_t    pix_out;

	//////////////////////////////////////////////////
	// video ram, one write and one read port
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (wr_en)
			vram[wr_addr[ADDR_W-1:0]] <= wr_data;
	end

	// raster order address, row major
	assign rd_addr = pixcount_t'(vcount) * pixcount_t'(cur_h) + pixcount_t'(hcount);

	always_ff @(posedge clk_sys) begin
		if (ce_pix)
			rd_q <= vram[rd_addr[ADDR_W-1:0]];
	end

	//////////////////////////////////////////////////
	// sync/de pipeline, same stage as the read
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vga_de <= 1'b0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			full_q <= 1'b0;
		end else if (ce_pix) begin
			vga_de <= active;
			vga_hs <= hsync;
			vga_vs <= vsync;
			full_q <= frame_full; // held with the pixel
		end
	end

	// blank outside de, fallback until vram holds a frame
	assign pix_out = !vga_de ? 24'h000000 : (full_q ? rd_q : FALLBACK_COLOR);

	assign vga_r = pix_out[23:16];
	assign vga_g = pix_out[15:8];
	assign vga_b = pix_out[7:0];

endmodule

/* hdl/video_top.sv */
//////////////////////////////////////////////////
// video frame engine top
// modeline latch, raster timing, blit writer, scanout
//////////////////////////////////////////////////

`timescale 1ns/1ns

module video_top #(
	parameter int VRAM_DEPTH = 4096
) (
	input  logic              clk_sys,
	input  logic              reset,
	// modeline port
	input  logic              mode_valid,
	output logic              mode_ready,
	input  video_pkg::coord_t mode_h,
	input  video_pkg::porch_t mode_hfp,
	input  video_pkg::porch_t mode_hs,
	input  video_pkg::porch_t mode_hbp,
	input  video_pkg::coord_t mode_v,
	input  video_pkg::porch_t mode_vfp,
	input  video_pkg::porch_t mode_vs,
	input  video_pkg::porch_t mode_vbp,
	input  video_pkg::cediv_t mode_ce_div,
	// pixel stream
	input  logic              px_valid,
	input  video_pkg::pixel_t px_data,
	output logic              px_ready,
	// video out
	output logic [7:0]        vga_r,
	output logic [7:0]        vga_g,
	output logic [7:0]        vga_b,
	output logic              vga_hs,
	output logic              vga_vs,
	output logic              vga_de
);
	import video_pkg::*;

	// active modeline
	coord_t    cur_h;
	porch_t    cur_hfp;
	porch_t    cur_hs;
	porch_t    cur_hbp;
	coord_t    cur_v;
	porch_t    cur_vfp;
	porch_t    cur_vs;
	porch_t    cur_vbp;
	cediv_t    cur_ce_div;
	logic      mode_apply;

	// raster state
	logic      ce_pix;
	coord_t    hcount;
	coord_t    vcount;
	logic      active;
	logic      hsync;
	logic      vsync;
	logic      vblank;
	logic      vblank_start;

	// vram write port
	logic      wr_en;
	pixcount_t wr_addr;
	pixel_t    wr_data;
	logic      frame_full;

	mode_latch u_mode_latch (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.vblank      (vblank),
		.mode_valid  (mode_valid),
		.mode_ready  (mode_ready),
		.mode_h      (mode_h),
		.mode_hfp    (mode_hfp),
		.mode_hs     (mode_hs),
		.mode_hbp    (mode_hbp),
		.mode_v      (mode_v),
		.mode_vfp    (mode_vfp),
		.mode_vs     (mode_vs),
		.mode_vbp    (mode_vbp),
		.mode_ce_div (mode_ce_div),
		.cur_h       (cur_h),
		.cur_hfp     (cur_hfp),
		.cur_hs      (cur_hs),
		.cur_hbp     (cur_hbp),
		.cur_v       (cur_v),
		.cur_vfp     (cur_vfp),
		.cur_vs      (cur_vs),
		.cur_vbp     (cur_vbp),
		.cur_ce_div  (cur_ce_div),
		.mode_apply  (mode_apply)
	);

	raster_timing u_raster_timing (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mode_apply   (mode_apply),
		.cur_h        (cur_h),
		.cur_hfp      (cur_hfp),
		.cur_hs       (cur_hs),
		.cur_hbp      (cur_hbp),
		.cur_v        (cur_v),
		.cur_vfp      (cur_vfp),
		.cur_vs       (cur_vs),
		.cur_vbp      (cur_vbp),
		.cur_ce_div   (cur_ce_div),
		.ce_pix       (ce_pix),
		.hcount       (hcount),
		.vcount       (vcount),
		.active       (active),
		.hsync        (hsync),
		.vsync        (vsync),
		.vblank       (vblank),
		.vblank_start (vblank_start)
	);

	blit_writer #(.VRAM_DEPTH(VRAM_DEPTH)) u_blit_writer (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mode_apply   (mode_apply),
		.vblank_start (vblank_start),
		.cur_h        (cur_h),
		.cur_v        (cur_v),
		.px_valid     (px_valid),
		.px_data      (px_data),
		.px_ready     (px_ready),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.frame_full   (frame_full)
	);

	scanout #(.VRAM_DEPTH(VRAM_DEPTH)) u_scanout (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ce_pix     (ce_pix),
		.active     (active),
		.hsync      (hsync),
		.vsync      (vsync),
		.hcount     (hcount),
		.vcount     (vcount),
		.cur_h      (cur_h),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.frame_full (frame_full),
		.vga_r      (vga_r),
		.vga_g      (vga_g),
		.vga_b      (vga_b),
		.vga_hs     (vga_hs),
		.vga_vs     (vga_vs),
		.vga_de     (vga_de)
	);

endmodule

/* verification/tb_video_top.sv */
//////////////////////////////////////////////////
// testbench for the video frame engine
// small modeline, blits, scanout and back-pressure
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_video_top;
	import video_pkg::*;

	// test modeline of 14 pixels by 7 lines at 2 clocks per pixel
	localparam int T_H   = 8;
	localparam int T_HFP = 2;
	localparam int T_HS  = 2;
	localparam int T_HBP = 2;
	localparam int T_V   = 4;
	localparam int T_VFP = 1;
	localparam int T_VS  = 1;
	localparam int T_VBP = 1;
	localparam int T_CE  = 2;

	localparam int LINE_PIX    = T_H + T_HFP + T_HS + T_HBP;
	localparam int FRAME_LINES = T_V + T_VFP + T_VS + T_VBP;
	localparam int FRAME_PIX   = T_H * T_V;      // visible pixels per frame
	localparam pixel_t DARK_YELLOW = 24'hd19628; // colour before a full frame

	localparam int BOOT_TIMEOUT  = 2000000; // default mode is slow to reach vblank
	localparam int FRAME_TIMEOUT = 1000;    // test frame is 196 clocks
	localparam int SEL_VS        = 0;
	localparam int SEL_VBLANK    = 1;

	logic   clk_sys;
	logic   reset;
	logic   mode_valid;
	logic   mode_ready;
	coord_t mode_h;
	porch_t mode_hfp;
	porch_t mode_hs;
	porch_t mode_hbp;
	coord_t mode_v;
	porch_t mode_vfp;
	porch_t mode_vs;
	porch_t mode_vbp;
	cediv_t mode_ce_div;
	logic   px_valid;
	pixel_t px_data;
	logic   px_ready;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic   vga_hs;
	logic   vga_vs;
	logic   vga_de;
	pixel_t rgb;

	integer seed = 32'hfd56;
	int     errors = 0;      // failed checks in the whole run
	int     test_errors = 0; // failed checks in the current test
	int     tests_run = 0;
	int     tests_failed = 0;
	int     de_cycles;       // de high clocks seen this frame
	logic   hung = 1'b0;     // some wait ran out
	pixel_t pushed[$];       // pixels sent to the dut
	pixel_t shown[$];        // pixels seen with de high

	assign rgb = {vga_r, vga_g, vga_b};

	video_top #(.VRAM_DEPTH(64)) uut (
		.clk_sys(clk_sys), .reset(reset),
		.mode_valid(mode_valid), .mode_ready(mode_ready),
		.mode_h(mode_h), .mode_hfp(mode_hfp), .mode_hs(mode_hs), .mode_hbp(mode_hbp),
		.mode_v(mode_v), .mode_vfp(mode_vfp), .mode_vs(mode_vs), .mode_vbp(mode_vbp),
		.mode_ce_div(mode_ce_div),
		.px_valid(px_valid), .px_data(px_data), .px_ready(px_ready),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#1; // drive and sample clear of the edge
	endtask

	task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Error %s: expected %h, actual %h", what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic note_stall(string msg);
		$display("%s", msg);
		hung = 1'b1;
		errors++;
		test_errors++;
	endtask

	task automatic report_test(string test);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
			$display("%s: FAILED with %0d errors", test, test_errors);
		end else begin
			$display("%s: ok", test);
		end
		test_errors = 0;
	endtask

	function automatic logic probe(int sel);
		return (sel == SEL_VS) ? vga_vs : mode_ready; // mode_ready follows vblank
	endfunction

	// edge of vga_vs or vblank towards level
	task automatic wait_edge(int sel, logic level, string test, string what);
		logic prev;
		int   n;
		n = 0;
		do begin
			prev = probe(sel);
			step();
			n++;
		end while (!(probe(sel) == level && prev != level) && n < FRAME_TIMEOUT);
		if (!(probe(sel) == level && prev != level))
			note_stall($sformatf("%s: no %s within %0d cycles", test, what, FRAME_TIMEOUT));
	endtask

	task automatic load_mode(string test);
		int n;
		mode_h      = coord_t'(T_H);
		mode_hfp    = porch_t'(T_HFP);
		mode_hs     = porch_t'(T_HS);
		mode_hbp    = porch_t'(T_HBP);
		mode_v      = coord_t'(T_V);
		mode_vfp    = porch_t'(T_VFP);
		mode_vs     = porch_t'(T_VS);
		mode_vbp    = porch_t'(T_VBP);
		mode_ce_div = cediv_t'(T_CE);
		mode_valid  = 1'b1;
		n = 0;
		while (!mode_ready && n < BOOT_TIMEOUT) begin
			step();
			n++;
		end
		if (!mode_ready)
			note_stall({test, ": mode_ready never went high"});
		else
			step(); // handshake edge
		mode_valid = 1'b0;
		step(); // apply pulse
		step(); // new modeline running
	endtask

	// one frame of random pixels with gaps of 0 or 1 clock
	task automatic push_pixels(string test);
		int n;
		int gap;
		pushed.delete();
		for (int i = 0; i < FRAME_PIX; i++) begin
			gap = $random(seed) & 1;
			px_valid = 1'b0;
			repeat (gap) step();
			px_data  = pixel_t'($random(seed));
			px_valid = 1'b1;
			n = 0;
			while (!px_ready && n < FRAME_TIMEOUT) begin
				step();
				n++;
			end
			if (!px_ready) begin
				note_stall({test, ": px_ready stuck low while filling"});
				break;
			end
			step(); // transfer edge
			pushed.push_back(px_data);
		end
		px_valid = 1'b0;
	endtask

	task automatic take_sample(string test);
		if (vga_de) begin
			if (de_cycles % T_CE == 0)
				shown.push_back(rgb); // first clock of each pixel
			de_cycles++;
		end else begin
			check_value({test, " blank rgb"}, 0, 32'(rgb));
		end
	endtask

	// samples from now up to the next vblank start
	task automatic capture_frame(string test);
		int n;
		shown.delete();
		de_cycles = 0;
		n = 0;
		while (!mode_ready && n < FRAME_TIMEOUT) begin
			take_sample(test);
			step();
			n++;
		end
		if (!mode_ready)
			note_stall({test, ": vblank never started again"});
	endtask

	// whole active frame once the current vblank ends
	task automatic scan_frame(string test);
		wait_edge(SEL_VBLANK, 1'b0, test, "end of vblank");
		if (hung)
			return;
		capture_frame(test);
	endtask

	task automatic check_frame(string test, logic expect_data);
		pixel_t want;
		check_value({test, " pixel count"}, FRAME_PIX, 32'(shown.size()));
		foreach (shown[i]) begin
			want = DARK_YELLOW;
			if (expect_data)
				want = (i < pushed.size()) ? pushed[i] : 24'h000000;
			check_value($sformatf("%s pixel %0d", test, i), 32'(want), 32'(shown[i]));
		end
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		check_value("reset_state vga_de", 0, 32'(vga_de));
		check_value("reset_state vga_hs", 0, 32'(vga_hs));
		check_value("reset_state vga_vs", 0, 32'(vga_vs));
		check_value("reset_state px_ready", 1, 32'(px_ready));
		check_value("reset_state mode_ready", 0, 32'(mode_ready));
		report_test("reset_state");
	endtask

	task automatic test_mode_timing();
		int   n;
		int   since_hs;
		int   hs_rises;
		logic hs_prev;
		logic vs_prev;
		load_mode("mode_timing");
		if (!hung)
			wait_edge(SEL_VS, 1'b1, "mode_timing", "vga_vs rise");
		if (!hung) begin
			since_hs = 0;
			hs_rises = 0;
			n = 0;
			do begin
				hs_prev = vga_hs;
				vs_prev = vga_vs;
				step();
				n++;
				since_hs++;
				if (vga_hs && !hs_prev) begin
					if (hs_rises > 0) // line length times divider
						check_value("mode_timing hsync period", LINE_PIX * T_CE, since_hs);
					hs_rises++;
					since_hs = 0;
				end
			end while (!(vga_vs && !vs_prev) && n < FRAME_TIMEOUT);
			if (!(vga_vs && !vs_prev))
				note_stall("mode_timing: second vga_vs rise never came");
			else
				check_value("mode_timing lines per frame", FRAME_LINES, hs_rises);
		end
		report_test("mode_timing");
	endtask

	task automatic test_fallback();
		scan_frame("fallback");
		if (!hung)
			check_frame("fallback", 1'b0);
		report_test("fallback");
	endtask

	task automatic test_blit_scanout();
		wait_edge(SEL_VBLANK, 1'b1, "blit_scanout", "vblank start");
		if (!hung)
			push_pixels("blit_scanout");
		if (!hung)
			scan_frame("blit_scanout"); // the frame right after the fill
		if (!hung)
			check_frame("blit_scanout", 1'b1);
		report_test("blit_scanout");
	endtask

	task automatic test_backpressure();
		int   n;
		logic left_vblank;
		wait_edge(SEL_VBLANK, 1'b1, "backpressure", "vblank start");
		if (!hung)
			push_pixels("backpressure");
		if (!hung) begin
			px_data  = pixel_t'($random(seed));
			px_valid = 1'b1; // held over the whole frame
			shown.delete();
			de_cycles = 0;
			left_vblank = 1'b0;
			n = 0;
			while (!(left_vblank && mode_ready) && n < FRAME_TIMEOUT) begin
				check_value("backpressure px_ready", 0, 32'(px_ready));
				if (!mode_ready)
					left_vblank = 1'b1;
				take_sample("backpressure");
				step();
				n++;
			end
			if (!(left_vblank && mode_ready))
				note_stall("backpressure: next vblank never started");
		end
		if (!hung) begin
			check_frame("backpressure", 1'b1); // first 32 still on screen
			n = 0;
			while (!px_ready && n < FRAME_TIMEOUT) begin
				step();
				n++;
			end
			if (!px_ready)
				note_stall("backpressure: held pixel never accepted after vblank start");
			else
				step(); // held pixel taken here
		end
		px_valid = 1'b0;
		report_test("backpressure");
	endtask

	task automatic test_mode_change();
		wait_edge(SEL_VBLANK, 1'b1, "mode_change", "vblank start");
		if (!hung)
			push_pixels("mode_change"); // frame full again, vram holds data
		if (!hung) begin
			check_value("mode_change px_ready before reload", 0, 32'(px_ready));
			load_mode("mode_change");
		end
		if (!hung) begin
			check_value("mode_change px_ready", 1, 32'(px_ready));
			capture_frame("mode_change"); // first frame of the reloaded mode
		end
		if (!hung)
			check_frame("mode_change", 1'b0);
		report_test("mode_change");
	endtask

	//////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////

	initial begin
		reset       = 1'b1;
		mode_valid  = 1'b0;
		mode_h      = '0;
		mode_hfp    = '0;
		mode_hs     = '0;
		mode_hbp    = '0;
		mode_v      = '0;
		mode_vfp    = '0;
		mode_vs     = '0;
		mode_vbp    = '0;
		mode_ce_div = '0;
		px_valid    = 1'b0;
		px_data     = '0;
		repeat (8) step();
		reset = 1'b0; // registers still hold reset values here
		test_reset_state();
		if (!hung)
			test_mode_timing();
		if (!hung)
			test_fallback();
		if (!hung)
			test_blit_scanout();
		if (!hung)
			test_backpressure();
		if (!hung)
			test_mode_change();
		$display("tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* project.f */
common/video_pkg.sv
hdl/mode_latch.sv
raster/raster_timing.sv
vram/blit_writer.sv
vram/scanout.sv
hdl/video_top.sv
verification/tb_video_top.sv

/* run.sh */
#!/bin/sh
# build and run tb_video_top with verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_video_top -f project.f \
	-o sim_video_top > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_video_top > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
